// ==== eggs_hatch_top.f ====
verilog/hatch_pkg.sv
verilog/btn_debounce.sv
verilog/hatch_timers.sv
verilog/hatch_fsm.sv
verilog/seg_display.sv
verilog/matrix_display.sv
verilog/eggs_hatch_top.sv
verif/eggs_hatch_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := eggs_hatch_tb
FILELIST  := eggs_hatch_top.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== verif/eggs_hatch_tb.sv ====
// testbench for the egg hatching game with a reference model and display compare
`timescale 1ns/1ps

module eggs_hatch_tb
    import hatch_pkg::*;
;

    logic       clk;
    logic       sw7;
    logic       btn0;
    logic       sw0;
    logic       led0;
    logic       led2;
    logic [7:0] row;
    logic [7:0] colg;
    logic [7:0] colr;
    logic [7:0] seg;
    logic [7:0] dig;

    // reference model of the game advanced on the rising edge
    hatch_state_t m_state;
    int           m_elapsed;
    int           m_stage;
    int           m_cold;
    int           m_cyc;
    logic         m_run;
    logic         btn_prev;
    int           arm_cnt;
    int           settle;
    int           scan_pos;
    int           m_dig;
    int           m_row;
    logic         check_en;
    int           seed;

    eggs_hatch_top uut (
        .clk  (clk),
        .sw7  (sw7),
        .btn0 (btn0),
        .sw0  (sw0),
        .led0 (led0),
        .led2 (led2),
        .row  (row),
        .colg (colg),
        .colr (colr),
        .seg  (seg),
        .dig  (dig)
    );

    always #5 clk = ~clk;

    // kind 0 gives seg, 1 gives colg, 2 gives colr
    function automatic logic [7:0] expected_frame(hatch_state_t st, int stg, int el,
                                                  int idx, int kind);
        logic [7:0] bar;
        bar = 8'((16'h1 << (stg / 2)) - 16'h1);
        if (kind == 0)
        begin
            return (idx == 0) ? SEG_FONT[el % 10] : SEG_FONT[el / 10];
        end
        case (st)
            READY:    return (kind == 1) ? EGG_ROWS[idx] : 8'h00;
            HATCHED:  return (kind == 1) ? CHICK_ROWS[idx] : 8'h00;
            FAILED:   return (kind == 1) ? 8'h00 : EGG_ROWS[idx];
            default:  return (kind == 1) ? EGG_ROWS[idx] : ((idx == 7) ? bar : 8'h00);
        endcase
    endfunction

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("** Error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic timeout_fail(string what);
        $display("timeout while waiting for %s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "timeout");
    endtask

    always @(posedge clk or negedge sw7)
    begin
        if (!sw7)
        begin
            m_state   = READY;
            m_elapsed = 0;
            m_stage   = 0;
            m_cold    = 0;
            m_cyc     = 0;
            m_run     = 1'b0;
            btn_prev  = 1'b0;
            arm_cnt   = 0;
            settle    = 4;
            scan_pos  = 0;
            m_dig     = 0;
            m_row     = 0;
        end
        else
        begin
            // both scans free-run from reset release
            m_dig    = (scan_pos / SCAN_CYCLES) % 2;
            m_row    = (scan_pos / SCAN_CYCLES) % 8;
            scan_pos = (scan_pos + 1) % (8 * SCAN_CYCLES);
            if (settle > 0)
                settle = settle - 1;
            if (m_run)
            begin
                m_cyc = m_cyc + 1;
                if (m_cyc > 1 && ((m_cyc - 1) % TICK_CYCLES) == 0)
                begin
                    settle = 10;
                    if (m_elapsed < 99)
                        m_elapsed = m_elapsed + 1;
                    m_stage = (m_elapsed / 2 > STAGE_HATCH) ? STAGE_HATCH : m_elapsed / 2;
                    if (!sw0 && m_cold < COLD_LIMIT)
                        m_cold = m_cold + 1;
                    if (m_state == INCUBATE && m_stage >= STAGE_GROW)
                        m_state = GROWING;
                    else if (m_state == INCUBATE && m_cold >= COLD_LIMIT)
                        m_state = FAILED;
                    else if (m_state == GROWING && m_stage >= STAGE_HATCH)
                        m_state = HATCHED;
                    m_run = (m_state == INCUBATE) || (m_state == GROWING);
                end
                if (sw0)
                    m_cold = 0;
            end
            // press lands two sync flops plus the filter after a steady rise
            if (!btn0)
            begin
                arm_cnt = 0;
            end
            else if (!btn_prev)
            begin
                arm_cnt = DEBOUNCE_CYCLES + 2;
            end
            else if (arm_cnt > 0)
            begin
                arm_cnt = arm_cnt - 1;
                if (arm_cnt == 0)
                begin
                    settle = 10;
                    if (m_state == READY)
                    begin
                        m_state   = INCUBATE;
                        m_elapsed = 0;
                        m_stage   = 0;
                        m_cold    = 0;
                        m_cyc     = 0;
                        m_run     = 1'b1;
                    end
                    else if (m_state == HATCHED || m_state == FAILED)
                    begin
                        m_state = READY;
                    end
                end
            end
            btn_prev = btn0;
        end
    end

    // compare on the falling edge where registered outputs are settled
    always @(negedge clk)
    begin
        if (check_en && sw7 && settle == 0)
        begin
            check_value("dig", {24'b0, ~(8'h01 << m_dig)}, {24'b0, dig});
            check_value("seg", {24'b0, expected_frame(m_state, m_stage, m_elapsed, m_dig, 0)},
                        {24'b0, seg});
            check_value("row", {24'b0, ~(8'h01 << m_row)}, {24'b0, row});
            check_value("colg", {24'b0, expected_frame(m_state, m_stage, m_elapsed, m_row, 1)},
                        {24'b0, colg});
            check_value("colr", {24'b0, expected_frame(m_state, m_stage, m_elapsed, m_row, 2)},
                        {24'b0, colr});
            check_value("led0", {31'b0, (m_state == INCUBATE) || (m_state == GROWING)},
                        {31'b0, led0});
            check_value("led2", {31'b0, m_state == HATCHED}, {31'b0, led2});
        end
    end

    task automatic wait_for_led(int which, logic value, int limit);
        int n;
        n = 0;
        while (((which == 0) ? led0 : led2) !== value)
        begin
            if (n >= limit)
                timeout_fail(which == 0 ? "led0" : "led2");
            @(negedge clk);
            n++;
        end
    endtask

    task automatic wait_game_cycle(int target);
        int n;
        n = 0;
        while (m_cyc < target)
        begin
            if (n >= target + 2000)
                timeout_fail("game time to advance");
            @(negedge clk);
            n++;
        end
    endtask

    task automatic press_button();
        @(negedge clk);
        btn0 = 1'b1;
        repeat (DEBOUNCE_CYCLES + 10) @(negedge clk);
        btn0 = 1'b0;
        repeat (DEBOUNCE_CYCLES + 10) @(negedge clk);
    endtask

    task automatic check_reset_values();
        check_value("led0", 32'h0, {31'b0, led0});
        check_value("led2", 32'h0, {31'b0, led2});
        check_value("dig", 32'hFF, {24'b0, dig});
        check_value("row", 32'hFF, {24'b0, row});
        check_value("seg", 32'h0, {24'b0, seg});
        check_value("colg", 32'h0, {24'b0, colg});
        check_value("colr", 32'h0, {24'b0, colr});
    endtask

    initial
    begin
        clk      = 1'b0;
        sw7      = 1'b0;
        btn0     = 1'b0;
        sw0      = 1'b1;
        check_en = 1'b0;
        seed     = 28;
        repeat (5) @(negedge clk);
        check_reset_values();
        repeat (5) @(negedge clk);
        sw7      = 1'b1;
        check_en = 1'b1;
        repeat (100) @(negedge clk);

        // bounce shorter than the filter must not start a game
        for (int i = 0; i < 12; i++)
        begin
            btn0 = 1'b1;
            repeat (1 + ($unsigned($random(seed)) % 15)) @(negedge clk);
            btn0 = 1'b0;
            repeat (1 + ($unsigned($random(seed)) % 15)) @(negedge clk);
        end
        repeat (40) @(negedge clk);
        check_value("led0", 32'h0, {31'b0, led0});
        @(negedge clk);
        btn0 = 1'b1;
        wait_for_led(0, 1'b1, DEBOUNCE_CYCLES + 10);
        @(negedge clk);
        btn0 = 1'b0;
        repeat (DEBOUNCE_CYCLES + 10) @(negedge clk);

        // heater on all the way to the hatch
        wait_for_led(1, 1'b1, 34 * TICK_CYCLES);
        check_value("hatch_seconds", 32'd32, m_elapsed);
        repeat (2 * TICK_CYCLES) @(negedge clk);
        press_button();
        check_value("led2", 32'h0, {31'b0, led2});
        repeat (200) @(negedge clk);

        // short cold spell survives and the long one kills the egg
        press_button();
        wait_game_cycle(2500);
        sw0 = 1'b0;
        wait_game_cycle(5500);
        sw0 = 1'b1;
        wait_game_cycle(6500);
        check_value("led0", 32'h1, {31'b0, led0});
        sw0 = 1'b0;
        wait_for_led(0, 1'b0, 6 * TICK_CYCLES);
        repeat (20) @(negedge clk);
        check_value("led2", 32'h0, {31'b0, led2});
        check_value("fail_state", {29'b0, FAILED}, {29'b0, m_state});
        repeat (TICK_CYCLES) @(negedge clk);
        sw0 = 1'b1;
        press_button();
        repeat (200) @(negedge clk);

        // cold during growing is ignored
        press_button();
        wait_game_cycle(21500);
        sw0 = 1'b0;
        wait_for_led(1, 1'b1, 15 * TICK_CYCLES);
        sw0 = 1'b1;
        press_button();
        repeat (200) @(negedge clk);

        // power switch drop in the middle of a game
        press_button();
        wait_game_cycle(3500);
        sw7 = 1'b0;
        #1;
        check_reset_values();
        repeat (10) @(negedge clk);
        sw7 = 1'b1;
        repeat (500) @(negedge clk);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== verilog/eggs_hatch_top.sv ====
// egg hatching game board top connecting button, timers, FSM and displays
`timescale 1ns/1ps

module eggs_hatch_top
    import hatch_pkg::*;
(
    input  logic       clk,
    input  logic       sw7,
    input  logic       btn0,
    input  logic       sw0,
    output logic       led0,
    output logic       led2,
    output logic [7:0] row,
    output logic [7:0] colg,
    output logic [7:0] colr,
    output logic [7:0] seg,
    output logic [7:0] dig
);

    logic         press;
    timer_ctrl_t  ctrl;
    timer_count_t counts;
    hatch_state_t state;

    btn_debounce u_debounce (
        .clk   (clk),
        .sw7   (sw7),
        .btn   (btn0),
        .press (press)
    );

    hatch_timers u_timers (
        .clk    (clk),
        .sw7    (sw7),
        .sw0    (sw0),
        .ctrl   (ctrl),
        .counts (counts)
    );

    hatch_fsm u_fsm (
        .clk    (clk),
        .sw7    (sw7),
        .press  (press),
        .counts (counts),
        .ctrl   (ctrl),
        .state  (state),
        .led0   (led0),
        .led2   (led2)
    );

    seg_display u_seg (
        .clk     (clk),
        .sw7     (sw7),
        .elapsed (counts.elapsed),
        .seg     (seg),
        .dig     (dig)
    );

    matrix_display u_matrix (
        .clk   (clk),
        .sw7   (sw7),
        .state (state),
        .stage (counts.stage),
        .row   (row),
        .colg  (colg),
        .colr  (colr)
    );

endmodule

// ==== verilog/matrix_display.sv ====
// picture selection and row scan of the 8x8 red/green dot matrix
`timescale 1ns/1ps

module matrix_display
    import hatch_pkg::*;
(
    input  logic         clk,
    input  logic         sw7,
    input  hatch_state_t state,
    input  logic [4:0]   stage,
    output logic [7:0]   row,
    output logic [7:0]   colg,
    output logic [7:0]   colr
);

    logic [SCAN_W-1:0] scan_cnt;
    logic [2:0]        row_idx;
    logic [7:0]        bar;
    logic [7:0]        green;
    logic [7:0]        red;

    // progress bar with stage/2 lit columns from bit 0 up
    always_comb
    begin
        for (int i = 0; i < 8; i++)
        begin
            bar[i] = (4'(i) < stage[4:1]);
        end
    end

    always_comb
    begin
        green = '0;
        red   = '0;
        case (state)
            READY:
            begin
                green = EGG_ROWS[row_idx];
            end
            INCUBATE, GROWING:
            begin
                green = EGG_ROWS[row_idx];
                if (row_idx == 3'd7)
                begin
                    red = bar;
                end
            end
            HATCHED:
            begin
                green = CHICK_ROWS[row_idx];
            end
            FAILED:
            begin
                red = EGG_ROWS[row_idx];
            end
            default:
            begin
                green = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge sw7)
    begin
        if (!sw7)
        begin
            scan_cnt <= '0;
            row_idx  <= '0;
            row      <= 8'hFF;
            colg     <= '0;
            colr     <= '0;
        end
        else
        begin
            if (scan_cnt == SCAN_W'(SCAN_CYCLES - 1))
            begin
                scan_cnt <= '0;
                row_idx  <= row_idx + 1'b1;
            end
            else
            begin
                scan_cnt <= scan_cnt + 1'b1;
            end
            // active row low, columns registered with it
            row  <= ~(8'b0000_0001 << row_idx);
            colg <= green;
            colr <= red;
        end
    end

endmodule

// ==== verilog/seg_display.sv ====
// two-digit decimal seven-segment display of the elapsed seconds
`timescale 1ns/1ps

module seg_display
    import hatch_pkg::*;
(
    input  logic       clk,
    input  logic       sw7,
    input  logic [6:0] elapsed,
    output logic [7:0] seg,
    output logic [7:0] dig
);

    logic [SCAN_W-1:0] scan_cnt;
    logic              sel;
    logic [6:0]        rem;
    logic [3:0]        tens;
    logic [3:0]        ones;

    // tens by repeated subtraction, elapsed never exceeds 99
    always_comb
    begin
        rem  = elapsed;
        tens = '0;
        for (int i = 0; i < 9; i++)
        begin
            if (rem >= 7'd10)
            begin
                rem  = rem - 7'd10;
                tens = tens + 1'b1;
            end
        end
        ones = rem[3:0];
    end

    always_ff @(posedge clk or negedge sw7)
    begin
        if (!sw7)
        begin
            scan_cnt <= '0;
            sel      <= 1'b0;
            seg      <= '0;
            dig      <= 8'hFF;
        end
        else
        begin
            if (scan_cnt == SCAN_W'(SCAN_CYCLES - 1))
            begin
                scan_cnt <= '0;
                sel      <= ~sel;
            end
            else
            begin
                scan_cnt <= scan_cnt + 1'b1;
            end
            // digit 1 shows tens, digit 0 ones, leading zero kept
            dig <= sel ? 8'b1111_1101 : 8'b1111_1110;
            seg <= SEG_FONT[sel ? tens : ones];
        end
    end

endmodule

// ==== verilog/hatch_fsm.sv ====
// game state machine steering the timers and the status LEDs
`timescale 1ns/1ps

module hatch_fsm
    import hatch_pkg::*;
(
    input  logic         clk,
    input  logic         sw7,
    input  logic         press,
    input  timer_count_t counts,
    output timer_ctrl_t  ctrl,
    output hatch_state_t state,
    output logic         led0,
    output logic         led2
);

    hatch_state_t next_state;
    logic         next_active;

    always_comb
    begin
        next_state = state;
        case (state)
            READY:
            begin
                if (press)
                begin
                    next_state = INCUBATE;
                end
            end
            INCUBATE:
            begin
                // limits are only ever reached on a tick
                if (counts.tick)
                begin
                    if (counts.stage >= 5'(STAGE_GROW))
                    begin
                        next_state = GROWING;
                    end
                    else if (counts.cold >= 3'(COLD_LIMIT))
                    begin
                        next_state = FAILED;
                    end
                end
            end
            GROWING:
            begin
                // temperature no longer matters here
                if (counts.tick && counts.stage >= 5'(STAGE_HATCH))
                begin
                    next_state = HATCHED;
                end
            end
            HATCHED, FAILED:
            begin
                if (press)
                begin
                    next_state = READY;
                end
            end
            default:
            begin
                next_state = READY;
            end
        endcase
    end

    assign next_active = (next_state == INCUBATE) || (next_state == GROWING);

    always_ff @(posedge clk or negedge sw7)
    begin
        if (!sw7)
        begin
            state <= READY;
            ctrl  <= '0;
            led0  <= 1'b0;
            led2  <= 1'b0;
        end
        else
        begin
            state      <= next_state;
            ctrl.run   <= next_active;
            ctrl.clear <= (state == READY) && press;
            led0       <= next_active;
            led2       <= (next_state == HATCHED);
        end
    end

endmodule

// ==== verilog/hatch_timers.sv ====
// game timers for the second tick, elapsed seconds, hatch stage and cold time
`timescale 1ns/1ps

module hatch_timers
    import hatch_pkg::*;
(
    input  logic         clk,
    input  logic         sw7,
    input  logic         sw0,
    input  timer_ctrl_t  ctrl,
    output timer_count_t counts
);

    logic [TICK_W-1:0] presc;
    logic              half;
    logic              sec_done;

    // last prescaler cycle of a game second
    assign sec_done = ctrl.run && (presc == TICK_W'(TICK_CYCLES - 1));

    always_ff @(posedge clk or negedge sw7)
    begin
        if (!sw7)
        begin
            presc  <= '0;
            half   <= 1'b0;
            counts <= '0;
        end
        else if (ctrl.clear)
        begin
            presc  <= '0;
            half   <= 1'b0;
            counts <= '0;
        end
        else
        begin
            counts.tick <= sec_done;
            // with run low everything holds, so the display freezes
            if (ctrl.run)
            begin
                if (sec_done)
                begin
                    presc <= '0;
                    half  <= ~half;
                    if (counts.elapsed != 7'(ELAPSED_MAX))
                    begin
                        counts.elapsed <= counts.elapsed + 1'b1;
                    end
                    // stage moves on every second tick
                    if (half && counts.stage != 5'(STAGE_HATCH))
                    begin
                        counts.stage <= counts.stage + 1'b1;
                    end
                    if (!sw0 && counts.cold != 3'(COLD_LIMIT))
                    begin
                        counts.cold <= counts.cold + 1'b1;
                    end
                end
                else
                begin
                    presc <= presc + 1'b1;
                end
                // heater on breaks the cold spell
                if (sw0)
                begin
                    counts.cold <= '0;
                end
            end
        end
    end

endmodule

// ==== verilog/btn_debounce.sv ====
// push button debouncer with a one-cycle pulse on each accepted press
`timescale 1ns/1ps

module btn_debounce
    import hatch_pkg::*;
(
    input  logic clk,
    input  logic sw7,
    input  logic btn,
    output logic press
);

    logic [1:0]       sync_q;
    logic             level_q;
    logic [DEB_W-1:0] stable_cnt;

    always_ff @(posedge clk or negedge sw7)
    begin
        if (!sw7)
        begin
            sync_q     <= '0;
            level_q    <= 1'b0;
            stable_cnt <= '0;
            press      <= 1'b0;
        end
        else
        begin
            sync_q <= {sync_q[0], btn};
            press  <= 1'b0;
            // any return to the accepted level restarts the filter
            if (sync_q[1] == level_q)
            begin
                stable_cnt <= '0;
            end
            else if (stable_cnt == DEB_W'(DEBOUNCE_CYCLES - 1))
            begin
                level_q    <= sync_q[1];
                stable_cnt <= '0;
                press      <= sync_q[1];
            end
            else
            begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== verilog/hatch_pkg.sv ====
// egg hatching game shared types, timing constants, bitmaps and control structs
package hatch_pkg;

    typedef enum logic [2:0] {
        READY    = 3'd0,
        INCUBATE = 3'd1,
        GROWING  = 3'd2,
        HATCHED  = 3'd3,
        FAILED   = 3'd4
    } hatch_state_t;

    // timing at the 1 kHz board clock
    localparam int TICK_CYCLES     = 1000;
    localparam int DEBOUNCE_CYCLES = 20;
    localparam int SCAN_CYCLES     = 4;
    localparam int TICK_W          = $clog2(TICK_CYCLES);
    localparam int DEB_W           = $clog2(DEBOUNCE_CYCLES);
    localparam int SCAN_W          = $clog2(SCAN_CYCLES);

    // game limits
    localparam int STAGE_GROW  = 10;
    localparam int STAGE_HATCH = 16;
    localparam int COLD_LIMIT  = 5;
    localparam int ELAPSED_MAX = 99;

    // bit i drives column i, entry 0 is the top row
    localparam logic [7:0] EGG_ROWS [0:7] = '{
        8'h18, 8'h3C, 8'h7E, 8'h7E, 8'hFF, 8'hFF, 8'h7E, 8'h3C
    };

    localparam logic [7:0] CHICK_ROWS [0:7] = '{
        8'h0C, 8'h1E, 8'h3B, 8'h7E, 8'hFE, 8'h7C, 8'h28, 8'h6C
    };

    // bit 0 is segment a up to bit 6 for g, bit 7 is dp
    localparam logic [7:0] SEG_FONT [0:9] = '{
        8'h3F, 8'h06, 8'h5B, 8'h4F, 8'h66, 8'h6D, 8'h7D, 8'h07, 8'h7F, 8'h6F
    };

    typedef struct packed {
        logic clear;
        logic run;
    } timer_ctrl_t;

    typedef struct packed {
        logic [6:0] elapsed;
        logic [4:0] stage;
        logic [2:0] cold;
        logic       tick;
    } timer_count_t;

endpackage
